// ==== rtl/activeListPkg.sv ====
// ==========================================================
// Shared sizes and types of the active list (reorder buffer)
// EntryNum must stay within what IndexPath can address
// RenameWidth and CommitWidth must fit in LaneCountPath
// ==========================================================
`default_nettype none

package activeListPkg;

    // Sizes
    localparam int EntryNum = 16;
    localparam int RenameWidth = 2;
    localparam int CommitWidth = 2;
    localparam int IssueWidth = 2;
    localparam int PcWidth = 32;
    localparam int RegNumWidth = 5;

    // Dispatch clears and writeback sets the finished bits
    localparam int StateWriteNum = RenameWidth + IssueWidth;

    typedef logic [3:0] IndexPath;
    typedef logic [4:0] CountPath;
    typedef logic [1:0] LaneCountPath;
    typedef logic [PcWidth-1:0] PcPath;

    typedef enum logic [2:0] {
        notFinished,
        success,
        refetchThis,
        refetchNext,
        trap
    } ExecState;

    typedef enum logic [1:0] {
        refetchThisPc,
        refetchNextPc,
        refetchBranchTarget
    } RefetchType;

    // Payload written at dispatch
    typedef struct packed {
        PcPath pc;
        logic [RegNumWidth-1:0] dstReg;
        logic isBranch;
        logic isStore;
        logic writesReg;
    } ActiveListEntry;

    // One execution writeback lane
    typedef struct packed {
        logic valid;
        IndexPath ptr;
        ExecState state;
        PcPath pc;
        logic isBranch;
    } ExecWrite;

    typedef struct packed {
        logic valid;
        IndexPath ptr;
        PcPath pc;
        ExecState state;
    } RecoveryReg;

    // Towards the recovery manager
    typedef struct packed {
        logic detectedInRwStage;
        RefetchType refetchType;
        PcPath recoveredPcRw;
        PcPath recoveredPcCommit;
        logic flushAllInsns;
    } RecoveryInfo;

endpackage

`default_nettype wire

// ==== rtl/multiPortRam.sv ====
// ==========================================================
// Distributed RAM with EntryNum words, no reset
// Writes land on the clock edge, reads are combinational
// On an address conflict the higher write port wins
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module multiPortRam #(
    parameter int EntryWidth = 1,
    parameter int WriteNum = 1,
    parameter int ReadNum = 1
) (
    input  logic clk,
    input  logic [WriteNum-1:0] we,
    input  activeListPkg::IndexPath [WriteNum-1:0] wa,
    input  logic [WriteNum-1:0][EntryWidth-1:0] wv,
    input  activeListPkg::IndexPath [ReadNum-1:0] ra,
    output logic [ReadNum-1:0][EntryWidth-1:0] rv
);
    import activeListPkg::*;

    logic [EntryWidth-1:0] mem [EntryNum];

    // Later ports overwrite earlier ones in loop order
    always_ff @(posedge clk) begin
        for (int i = 0; i < WriteNum; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ReadNum; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/queuePointer.sv ====
// ==========================================================
// Head, tail and occupancy of the circular active list
// The caller must not pop more entries than are valid,
// and must not pop head and tail in the same cycle
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module queuePointer (
    input  logic clk,
    input  logic rst,
    input  logic [activeListPkg::RenameWidth-1:0] pushTail,
    input  activeListPkg::LaneCountPath popHeadNum,
    input  activeListPkg::LaneCountPath popTailNum,
    output activeListPkg::IndexPath headPtr,
    output activeListPkg::IndexPath tailPtr,
    output activeListPkg::IndexPath [activeListPkg::CommitWidth-1:0] headPtrList,
    output activeListPkg::IndexPath [activeListPkg::CommitWidth-1:0] readPtrList,
    output activeListPkg::IndexPath [activeListPkg::RenameWidth-1:0] pushedTailPtr,
    output activeListPkg::IndexPath detectedFlushRangeTailPtr,
    output activeListPkg::CountPath count,
    output logic allocatable,
    output logic activeListEmpty
);
    import activeListPkg::*;

    LaneCountPath pushNum;

    // Offset stays within one lap in either direction
    function automatic IndexPath wrapAdd(input IndexPath base, input int offset);
        int sum;
        sum = int'(base) + offset;
        if (sum >= EntryNum) begin
            sum = sum - EntryNum;
        end
        else if (sum < 0) begin
            sum = sum + EntryNum;
        end
        return IndexPath'(sum);
    endfunction

    always_comb begin
        // Set lanes take consecutive slots in lane order
        pushNum = '0;
        for (int i = 0; i < RenameWidth; i++) begin
            pushedTailPtr[i] = wrapAdd(tailPtr, int'(pushNum));
            pushNum = pushNum + LaneCountPath'(pushTail[i]);
        end

        for (int i = 0; i < CommitWidth; i++) begin
            headPtrList[i] = wrapAdd(headPtr, i);
        end

        // Tail pop reads youngest first
        for (int i = 0; i < CommitWidth; i++) begin
            if (popTailNum != '0) begin
                readPtrList[i] = wrapAdd(tailPtr, -1 - i);
            end
            else begin
                readPtrList[i] = headPtrList[i];
            end
        end

        detectedFlushRangeTailPtr = wrapAdd(tailPtr, int'(pushNum));
        allocatable = count <= CountPath'(EntryNum - RenameWidth);
        activeListEmpty = count == '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end
        else begin
            headPtr <= wrapAdd(headPtr, int'(popHeadNum));
            tailPtr <= wrapAdd(tailPtr, int'(pushNum) - int'(popTailNum));
            count <= count + CountPath'(pushNum) - CountPath'(popHeadNum)
                - CountPath'(popTailNum);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/execStateTable.sv ====
// ==========================================================
// One finished bit per entry, cleared at dispatch and set
// at writeback; fault states live only in the recovery register
// Head lanes past the valid count read stale bits
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module execStateTable (
    input  logic clk,
    input  logic rst,
    input  logic [activeListPkg::RenameWidth-1:0] pushTail,
    input  activeListPkg::IndexPath [activeListPkg::RenameWidth-1:0] pushedTailPtr,
    input  activeListPkg::ExecWrite [activeListPkg::IssueWidth-1:0] execWrite,
    input  activeListPkg::IndexPath [activeListPkg::CommitWidth-1:0] headPtrList,
    input  activeListPkg::RecoveryReg recoveryReg,
    output activeListPkg::ExecState [activeListPkg::CommitWidth-1:0] headExecState
);
    import activeListPkg::*;

    logic [StateWriteNum-1:0] esWe;
    IndexPath [StateWriteNum-1:0] esWa;
    logic [StateWriteNum-1:0] esWv;
    logic [CommitWidth-1:0] esRv;

    // Dispatch ports first so writeback wins on the same slot
    always_comb begin
        for (int i = 0; i < RenameWidth; i++) begin
            esWe[i] = pushTail[i] && !rst;
            esWa[i] = pushedTailPtr[i];
            esWv[i] = 1'b0;
        end
        for (int i = 0; i < IssueWidth; i++) begin
            esWe[RenameWidth + i] = execWrite[i].valid && !rst;
            esWa[RenameWidth + i] = execWrite[i].ptr;
            esWv[RenameWidth + i] = execWrite[i].state != notFinished;
        end
    end

    multiPortRam #(
        .EntryWidth(1),
        .WriteNum(StateWriteNum),
        .ReadNum(CommitWidth)
    ) finishedBits (
        .clk(clk),
        .we(esWe),
        .wa(esWa),
        .wv(esWv),
        .ra(headPtrList),
        .rv(esRv)
    );

    // Recorded fault overrides the plain finished bit
    always_comb begin
        for (int i = 0; i < CommitWidth; i++) begin
            if (recoveryReg.valid && headPtrList[i] == recoveryReg.ptr) begin
                headExecState[i] = recoveryReg.state;
            end
            else if (esRv[i]) begin
                headExecState[i] = success;
            end
            else begin
                headExecState[i] = notFinished;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/recoveryTracker.sv ====
// ==========================================================
// Keeps the oldest faulting op seen at writeback
// Refetch faults start recovery at once unless blocked;
// traps wait in the register until commit
// The flush count is registered on toRecoveryPhase
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module recoveryTracker (
    input  logic clk,
    input  logic rst,
    input  activeListPkg::ExecWrite [activeListPkg::IssueWidth-1:0] execWrite,
    input  activeListPkg::IndexPath headPtr,
    input  activeListPkg::CountPath count,
    input  logic toRecoveryPhase,
    input  logic unableToStartRecovery,
    input  activeListPkg::IndexPath flushRangeHeadPtr,
    input  activeListPkg::IndexPath flushRangeTailPtr,
    output activeListPkg::RecoveryReg recoveryReg,
    output activeListPkg::RecoveryInfo recovery,
    output activeListPkg::CountPath recoveryEntryNum,
    output activeListPkg::IndexPath exceptionOpPtr
);
    import activeListPkg::*;

    RecoveryReg nextRecoveryReg;
    IndexPath oldestAge;
    IndexPath writeAge [IssueWidth];
    logic exceptionDetected;
    logic startAtCommit;
    RefetchType refetchType;
    CountPath nextEntryNum;
    logic flushAll;

    // Age is the distance from the head, smaller is older
    always_comb begin
        nextRecoveryReg = recoveryReg;
        oldestAge = recoveryReg.ptr - headPtr;
        exceptionDetected = 1'b0;
        startAtCommit = 1'b0;
        refetchType = refetchThisPc;

        for (int i = 0; i < IssueWidth; i++) begin
            writeAge[i] = execWrite[i].ptr - headPtr;
            if (execWrite[i].valid && !(execWrite[i].state inside {notFinished, success})) begin
                if (!nextRecoveryReg.valid || writeAge[i] < oldestAge) begin
                    oldestAge = writeAge[i];
                    nextRecoveryReg.valid = 1'b1;
                    nextRecoveryReg.ptr = execWrite[i].ptr;
                    nextRecoveryReg.pc = execWrite[i].pc;
                    nextRecoveryReg.state = execWrite[i].state;
                    exceptionDetected = execWrite[i].state inside {refetchThis, refetchNext};
                    startAtCommit = !exceptionDetected;
                    if (execWrite[i].state == refetchNext) begin
                        refetchType = execWrite[i].isBranch ? refetchBranchTarget
                                                            : refetchNextPc;
                    end
                    else begin
                        refetchType = refetchThisPc;
                    end
                end
            end
        end

        // Recovery already handled, so commit must not see the fault again
        if (exceptionDetected && !unableToStartRecovery) begin
            nextRecoveryReg.state = success;
        end
    end

    // Equal pointers mean empty or full, count tells them apart
    always_comb begin
        flushAll = 1'b0;
        if (flushRangeHeadPtr == flushRangeTailPtr && count == CountPath'(EntryNum)) begin
            nextEntryNum = CountPath'(EntryNum);
            flushAll = 1'b1;
        end
        else if (flushRangeTailPtr >= flushRangeHeadPtr) begin
            nextEntryNum = CountPath'(flushRangeTailPtr) - CountPath'(flushRangeHeadPtr);
        end
        else begin
            nextEntryNum = CountPath'(EntryNum) + CountPath'(flushRangeTailPtr)
                - CountPath'(flushRangeHeadPtr);
        end
    end

    // Kept across toRecoveryPhase if a new fault arrives or a trap is pending
    always_ff @(posedge clk) begin
        if (rst || (toRecoveryPhase && !exceptionDetected && !startAtCommit)) begin
            recoveryReg <= '0;
        end
        else begin
            recoveryReg <= nextRecoveryReg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            recoveryEntryNum <= '0;
        end
        else if (toRecoveryPhase) begin
            recoveryEntryNum <= nextEntryNum;
        end
    end

    always_comb begin
        recovery.detectedInRwStage = exceptionDetected && !unableToStartRecovery;
        recovery.refetchType = refetchType;
        recovery.recoveredPcRw = nextRecoveryReg.pc;
        recovery.recoveredPcCommit = recoveryReg.pc;
        recovery.flushAllInsns = flushAll;
        exceptionOpPtr = nextRecoveryReg.ptr;
    end

endmodule

`default_nettype wire

// ==== rtl/activeList.sv ====
// ==========================================================
// Active list of an out-of-order core, 16-entry circular FIFO
// No handshake: push only while allocatable is high, pop
// at most the valid entries, never head and tail together
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module activeList (
    input  logic clk,
    input  logic rst,
    // Dispatch
    input  logic [activeListPkg::RenameWidth-1:0] pushTail,
    input  activeListPkg::ActiveListEntry [activeListPkg::RenameWidth-1:0] pushedTailData,
    output activeListPkg::IndexPath [activeListPkg::RenameWidth-1:0] pushedTailPtr,
    output activeListPkg::IndexPath detectedFlushRangeTailPtr,
    output logic allocatable,
    // Commit and tail pop
    input  activeListPkg::LaneCountPath popHeadNum,
    input  activeListPkg::LaneCountPath popTailNum,
    output activeListPkg::ActiveListEntry [activeListPkg::CommitWidth-1:0] readData,
    output activeListPkg::ExecState [activeListPkg::CommitWidth-1:0] headExecState,
    output activeListPkg::CountPath validEntryNum,
    output logic activeListEmpty,
    // Writeback
    input  activeListPkg::ExecWrite [activeListPkg::IssueWidth-1:0] execWrite,
    // Recovery manager
    input  logic toRecoveryPhase,
    input  logic unableToStartRecovery,
    input  activeListPkg::IndexPath flushRangeHeadPtr,
    input  activeListPkg::IndexPath flushRangeTailPtr,
    output activeListPkg::RecoveryInfo recovery,
    output activeListPkg::CountPath recoveryEntryNum,
    output activeListPkg::IndexPath exceptionOpPtr
);
    import activeListPkg::*;

    IndexPath headPtr;
    IndexPath [CommitWidth-1:0] headPtrList;
    IndexPath [CommitWidth-1:0] readPtrList;
    RecoveryReg recoveryReg;

    queuePointer pointer (
        .clk(clk),
        .rst(rst),
        .pushTail(pushTail),
        .popHeadNum(popHeadNum),
        .popTailNum(popTailNum),
        .headPtr(headPtr),
        .tailPtr(),
        .headPtrList(headPtrList),
        .readPtrList(readPtrList),
        .pushedTailPtr(pushedTailPtr),
        .detectedFlushRangeTailPtr(detectedFlushRangeTailPtr),
        .count(validEntryNum),
        .allocatable(allocatable),
        .activeListEmpty(activeListEmpty)
    );

    // Payload, read at the head or at the tail during a tail pop
    multiPortRam #(
        .EntryWidth($bits(ActiveListEntry)),
        .WriteNum(RenameWidth),
        .ReadNum(CommitWidth)
    ) payload (
        .clk(clk),
        .we(pushTail),
        .wa(pushedTailPtr),
        .wv(pushedTailData),
        .ra(readPtrList),
        .rv(readData)
    );

    execStateTable stateTable (
        .clk(clk),
        .rst(rst),
        .pushTail(pushTail),
        .pushedTailPtr(pushedTailPtr),
        .execWrite(execWrite),
        .headPtrList(headPtrList),
        .recoveryReg(recoveryReg),
        .headExecState(headExecState)
    );

    recoveryTracker tracker (
        .clk(clk),
        .rst(rst),
        .execWrite(execWrite),
        .headPtr(headPtr),
        .count(validEntryNum),
        .toRecoveryPhase(toRecoveryPhase),
        .unableToStartRecovery(unableToStartRecovery),
        .flushRangeHeadPtr(flushRangeHeadPtr),
        .flushRangeTailPtr(flushRangeTailPtr),
        .recoveryReg(recoveryReg),
        .recovery(recovery),
        .recoveryEntryNum(recoveryEntryNum),
        .exceptionOpPtr(exceptionOpPtr)
    );

endmodule

`default_nettype wire

// ==== dv/activeListChecker.sv ====
// ==========================================================
// Concurrent assertions on the active list, bound to the top
// Checks are off while rst is high
// failCount lets the testbench see assertion failures
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module activeListChecker (
    input  logic clk,
    input  logic rst,
    input  activeListPkg::CountPath validEntryNum,
    input  logic allocatable,
    input  logic activeListEmpty,
    input  activeListPkg::RecoveryInfo recovery,
    input  logic unableToStartRecovery
);
    import activeListPkg::*;

    int failCount = 0;

    occupancyLimit: assert property (@(posedge clk) disable iff (rst)
        validEntryNum <= CountPath'(EntryNum))
    else begin
        $error("occupancy above EntryNum");
        failCount++;
    end

    // Room must remain for a full dispatch group
    allocatableRule: assert property (@(posedge clk) disable iff (rst)
        allocatable == (validEntryNum <= CountPath'(EntryNum - RenameWidth)))
    else begin
        $error("allocatable does not follow occupancy");
        failCount++;
    end

    emptyRule: assert property (@(posedge clk) disable iff (rst)
        activeListEmpty == (validEntryNum == '0))
    else begin
        $error("activeListEmpty does not follow a zero count");
        failCount++;
    end

    blockedRecovery: assert property (@(posedge clk) disable iff (rst)
        !(recovery.detectedInRwStage && unableToStartRecovery))
    else begin
        $error("recovery started while blocked");
        failCount++;
    end

endmodule

bind activeList activeListChecker checkerInst (
    .clk(clk),
    .rst(rst),
    .validEntryNum(validEntryNum),
    .allocatable(allocatable),
    .activeListEmpty(activeListEmpty),
    .recovery(recovery),
    .unableToStartRecovery(unableToStartRecovery)
);

`default_nettype wire

// ==== dv/activeListTb.sv ====
// ==========================================================
// Testbench for the active list with a queue-based FIFO model
// Inputs change 1 ns after the rising edge, checks at +5 ns
// Random stimulus uses a fixed xorshift seed
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module activeListTb;
    import activeListPkg::*;

    logic clk;
    logic rst;
    logic [RenameWidth-1:0] pushTail;
    ActiveListEntry [RenameWidth-1:0] pushedTailData;
    IndexPath [RenameWidth-1:0] pushedTailPtr;
    IndexPath detectedFlushRangeTailPtr;
    logic allocatable;
    LaneCountPath popHeadNum;
    LaneCountPath popTailNum;
    ActiveListEntry [CommitWidth-1:0] readData;
    ExecState [CommitWidth-1:0] headExecState;
    CountPath validEntryNum;
    logic activeListEmpty;
    ExecWrite [IssueWidth-1:0] execWrite;
    logic toRecoveryPhase;
    logic unableToStartRecovery;
    IndexPath flushRangeHeadPtr;
    IndexPath flushRangeTailPtr;
    RecoveryInfo recovery;
    CountPath recoveryEntryNum;
    IndexPath exceptionOpPtr;

    ActiveListEntry model[$];
    IndexPath modelTail;
    int errors = 0;
    logic [31:0] seed = 32'd54771;

    activeList UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (expected === actual)
        else begin
            $display("Error at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Inputs return to idle each cycle unless set again
    task automatic nextCycle();
        @(posedge clk);
        #1;
        pushTail = '0;
        popHeadNum = '0;
        popTailNum = '0;
        execWrite = '0;
        toRecoveryPhase = 1'b0;
    endtask

    task automatic checkHead();
        checkValue("validEntryNum", 64'(model.size()), 64'(validEntryNum));
        checkValue("allocatable", 64'(model.size() <= EntryNum - RenameWidth),
                   64'(allocatable));
        if (model.size() > 0) checkValue("readData[0]", 64'(model[0]), 64'(readData[0]));
        if (model.size() > 1) checkValue("readData[1]", 64'(model[1]), 64'(readData[1]));
    endtask

    // Set lanes take the next model slots in lane order
    task automatic recordPush();
        IndexPath slot;
        slot = modelTail;
        for (int i = 0; i < RenameWidth; i++) begin
            if (pushTail[i]) begin
                checkValue("pushedTailPtr", 64'(slot), 64'(pushedTailPtr[i]));
                model.push_back(pushedTailData[i]);
                slot = slot + 1'b1;
            end
        end
        checkValue("detectedFlushRangeTailPtr", 64'(slot), 64'(detectedFlushRangeTailPtr));
        modelTail = slot;
    endtask

    function automatic ActiveListEntry makeEntry(input logic [31:0] r);
        ActiveListEntry e;
        e.pc = {r[29:0], 2'b00};
        e.dstReg = r[4:0];
        e.isBranch = r[30];
        e.isStore = r[31];
        e.writesReg = r[5];
        return e;
    endfunction

    initial begin
        IndexPath ptrA;
        IndexPath ptrB;
        IndexPath ptrC;
        IndexPath rangeHead;
        IndexPath rangeTail;
        int pops;
        int guard;

        rst = 1'b1;
        pushTail = '0;
        pushedTailData = '0;
        popHeadNum = '0;
        popTailNum = '0;
        execWrite = '0;
        toRecoveryPhase = 1'b0;
        unableToStartRecovery = 1'b0;
        flushRangeHeadPtr = '0;
        flushRangeTailPtr = '0;
        modelTail = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // After reset
        #4;
        checkValue("validEntryNum", 64'd0, 64'(validEntryNum));
        checkValue("activeListEmpty", 64'd1, 64'(activeListEmpty));
        checkValue("allocatable", 64'd1, 64'(allocatable));

        // Random dispatch and head pops against the model
        for (int n = 0; n < 300; n++) begin
            nextCycle();
            seed = xorshift32(seed);
            pops = seed[3:2] % 3;
            if (pops > model.size()) pops = model.size();
            popHeadNum = LaneCountPath'(pops);
            if (allocatable) pushTail = seed[1:0];
            for (int i = 0; i < RenameWidth; i++) begin
                seed = xorshift32(seed);
                pushedTailData[i] = makeEntry(seed);
            end
            #4;
            checkHead();
            repeat (pops) void'(model.pop_front());
            recordPush();
        end

        // Drain the list
        guard = 0;
        while (model.size() > 0 && guard < 20) begin
            nextCycle();
            pops = model.size() > 2 ? 2 : model.size();
            popHeadNum = LaneCountPath'(pops);
            #4;
            checkHead();
            repeat (pops) void'(model.pop_front());
            guard++;
        end
        if (model.size() > 0) begin
            $display("Timeout while draining the active list");
            errors++;
        end

        // New entry is unfinished, then success after writeback
        nextCycle();
        pushTail = 2'b01;
        pushedTailData[0] = makeEntry(32'h1234_5678);
        #4;
        ptrA = modelTail;
        recordPush();
        nextCycle();
        execWrite[0] = '{valid: 1'b1, ptr: ptrA, state: success, pc: 32'h0000_0000,
                         isBranch: 1'b0};
        #4;
        checkHead();
        checkValue("headExecState[0]", 64'(notFinished), 64'(headExecState[0]));

        // Two refetchNext lanes, the older one must win
        nextCycle();
        pushTail = 2'b11;
        pushedTailData[0] = makeEntry(32'h4000_0100);
        pushedTailData[1] = makeEntry(32'h0000_0200);
        #4;
        checkValue("headExecState[0]", 64'(success), 64'(headExecState[0]));
        ptrB = modelTail;
        ptrC = modelTail + 1'b1;
        recordPush();
        rangeTail = modelTail;
        nextCycle();
        execWrite[0] = '{valid: 1'b1, ptr: ptrC, state: refetchNext, pc: 32'h0000_0800,
                         isBranch: 1'b0};
        execWrite[1] = '{valid: 1'b1, ptr: ptrB, state: refetchNext, pc: 32'h0000_0400,
                         isBranch: 1'b1};
        #4;
        checkValue("detectedInRwStage", 64'd1, 64'(recovery.detectedInRwStage));
        checkValue("recoveredPcRw", 64'h400, 64'(recovery.recoveredPcRw));
        checkValue("exceptionOpPtr", 64'(ptrB), 64'(exceptionOpPtr));
        checkValue("refetchType", 64'(refetchBranchTarget), 64'(recovery.refetchType));

        // Flush from the faulting op to the tail
        nextCycle();
        toRecoveryPhase = 1'b1;
        rangeHead = ptrB;
        flushRangeHeadPtr = rangeHead;
        flushRangeTailPtr = rangeTail;
        #4;
        checkValue("recoveredPcCommit", 64'h400, 64'(recovery.recoveredPcCommit));
        checkValue("flushAllInsns", 64'd0, 64'(recovery.flushAllInsns));

        // Blocked refetch stays recorded for commit
        nextCycle();
        unableToStartRecovery = 1'b1;
        execWrite[0] = '{valid: 1'b1, ptr: ptrB, state: refetchThis, pc: 32'h0000_0a00,
                         isBranch: 1'b0};
        #4;
        checkValue("recoveryEntryNum", 64'(IndexPath'(rangeTail - rangeHead)),
                   64'(recoveryEntryNum));
        checkValue("detectedInRwStage", 64'd0, 64'(recovery.detectedInRwStage));
        checkValue("exceptionOpPtr", 64'(ptrB), 64'(exceptionOpPtr));
        checkValue("refetchType", 64'(refetchThisPc), 64'(recovery.refetchType));

        // Trap is held for commit
        nextCycle();
        unableToStartRecovery = 1'b0;
        execWrite[0] = '{valid: 1'b1, ptr: ptrA, state: trap, pc: 32'h0000_0900,
                         isBranch: 1'b0};
        #4;
        checkValue("headExecState[1]", 64'(refetchThis), 64'(headExecState[1]));
        checkValue("recoveredPcCommit", 64'ha00, 64'(recovery.recoveredPcCommit));
        checkValue("detectedInRwStage", 64'd0, 64'(recovery.detectedInRwStage));
        nextCycle();
        #4;
        checkValue("headExecState[0]", 64'(trap), 64'(headExecState[0]));
        checkValue("recoveredPcCommit", 64'h900, 64'(recovery.recoveredPcCommit));

        // Fill the list to exactly EntryNum entries
        nextCycle();
        guard = 0;
        while (allocatable && guard < 20) begin
            pushTail = (model.size() % 2 == 1) ? 2'b01 : 2'b11;
            for (int i = 0; i < RenameWidth; i++) begin
                seed = xorshift32(seed);
                pushedTailData[i] = makeEntry(seed);
            end
            #4;
            recordPush();
            nextCycle();
            guard++;
        end
        if (allocatable) begin
            $display("Timeout while filling the active list");
            errors++;
        end

        // Full list with equal range pointers flushes everything
        toRecoveryPhase = 1'b1;
        flushRangeHeadPtr = modelTail;
        flushRangeTailPtr = modelTail;
        #4;
        checkHead();
        checkValue("flushAllInsns", 64'd1, 64'(recovery.flushAllInsns));

        // Tail pops read youngest first
        nextCycle();
        popTailNum = 2'd2;
        #4;
        checkValue("recoveryEntryNum", 64'(EntryNum), 64'(recoveryEntryNum));
        checkValue("readData[0]", 64'(model[model.size() - 1]), 64'(readData[0]));
        checkValue("readData[1]", 64'(model[model.size() - 2]), 64'(readData[1]));
        void'(model.pop_back());
        void'(model.pop_back());
        modelTail = modelTail - 2'd2;
        nextCycle();
        popTailNum = 2'd1;
        #4;
        checkValue("validEntryNum", 64'(model.size()), 64'(validEntryNum));
        checkValue("readData[0]", 64'(model[model.size() - 1]), 64'(readData[0]));
        void'(model.pop_back());
        modelTail = modelTail - 1'b1;
        nextCycle();
        #4;
        checkHead();
        recordPush();

        nextCycle();
        $display("Check errors: %0d, assertion failures: %0d", errors,
                 UUT.checkerInst.failCount);
        if (errors == 0 && UUT.checkerInst.failCount == 0) begin
            $display("TB PASSED");
        end
        else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/activeListPkg.sv
rtl/multiPortRam.sv
rtl/queuePointer.sv
rtl/execStateTable.sv
rtl/recoveryTracker.sv
rtl/activeList.sv
dv/activeListChecker.sv
dv/activeListTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = activeListTb
FILELIST = sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
